// File: Makefile
# Verilator build and run for the camera capture front end

VERILATOR ?= verilator
TOP       ?= camera_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000

SOURCES := $(filter %.sv %.v,$(shell cat $(FILE_LIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	-$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/camera_tb.sv
// Camera interface testbench with a glitchy sensor model and a line schedule reference
`timescale 1ns/1ps

module camera_tb
    import camera_pkg::*;
();

    localparam int sync_stages        = 10;
    localparam int sample_delay       = 2;
    localparam int line_size          = 8;
    localparam int lines_in_frame     = 16;
    localparam int interleaved_frames = 2;

    // Sensor geometry in pixel clock periods where one period is 8 system clocks
    localparam int period_clocks     = 8;
    localparam int frame_gap_periods = 6;
    localparam int porch_periods     = 2;
    localparam int line_gap_periods  = 4;
    localparam int frame_clocks      = period_clocks * (frame_gap_periods + porch_periods
                                     + lines_in_frame * (line_size + line_gap_periods));
    localparam int sensor_frames     = 4;
    localparam int timeout_cycles    = sensor_frames * frame_clocks + 1000;
    localparam int total_pixels      = lines_in_frame * line_size;
    localparam int request_delay     = 300;

    logic                  clk;
    logic                  reset;
    logic                  pixel_clock;
    logic                  frame_valid;
    logic                  line_valid;
    logic [pixel_bits-1:0] pixel_in;
    logic                  request_image;
    logic [fifo_bits-1:0]  data_for_fifo;
    logic                  sample_pixel_pulse;
    logic                  keep_pixel;
    logic                  image_started;
    logic                  image_finished;

    logic [31:0] rng_state = 32'hf57dcd76;
    int          byte_errors = 0;
    int          flag_errors = 0;
    int          assertion_errors = 0;
    int          cycle_count = 0;
    int          kept_count = 0;
    int          run_count = 0;
    logic        prev_keep;
    logic        prev_finished;

    camera_interface #(
        .sync_stages        (sync_stages),
        .sample_delay       (sample_delay),
        .line_size          (line_size),
        .lines_in_frame     (lines_in_frame),
        .interleaved_frames (interleaved_frames)
    ) camera_interface_inst (
        .clk                (clk),
        .reset              (reset),
        .pixel_clock        (pixel_clock),
        .frame_valid        (frame_valid),
        .line_valid         (line_valid),
        .pixel_in           (pixel_in),
        .request_image      (request_image),
        .data_for_fifo      (data_for_fifo),
        .sample_pixel_pulse (sample_pixel_pulse),
        .keep_pixel         (keep_pixel),
        .image_started      (image_started),
        .image_finished     (image_finished)
    );

    bind camera_interface camera_tb_properties camera_tb_properties_inst (
        .clk                (clk),
        .reset              (reset),
        .sample_pixel_pulse (sample_pixel_pulse),
        .keep_pixel         (keep_pixel),
        .image_started      (image_started),
        .image_finished     (image_finished)
    );

    always #5 clk = ~clk;

    // ************************************************************
    // Reference model and stimulus helpers
    // ************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Upper byte carries the line and pixel numbers and the lower nibble is a fixed marker
    function automatic logic [pixel_bits-1:0] pixel_word(input int line, input int pixel);
        return {4'(line), 4'(pixel), 4'h5};
    endfunction

    // Walks the Bayer pair schedule n steps from line 0 of the first sensor frame
    function automatic int expected_line(input int n);
        int target;
        int in_frame;
        int frame;
        target = 0;
        in_frame = 0;
        frame = 0;
        for (int i = 0; i < n; i++) begin
            if (in_frame == lines_in_frame / interleaved_frames - 1) begin
                // Each later sensor frame starts two lines lower
                frame++;
                in_frame = 0;
                target = 2 * frame;
            end else begin
                in_frame++;
                if (target % 2 == 0) begin
                    target = target + 1;
                end else if (target + 2 * interleaved_frames - 1 < lines_in_frame) begin
                    target = target + 2 * interleaved_frames - 1;
                end else begin
                    target = target + interleaved_frames;
                end
            end
        end
        return target;
    endfunction

    task automatic check_byte(input logic [fifo_bits-1:0] actual,
                              input logic [fifo_bits-1:0] expected, input string what);
        if (actual !== expected) begin
            byte_errors++;
            $display("CHECK FAILED at %0t: %s, expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            flag_errors++;
            $display("CHECK FAILED at %0t: %s, expected %b, got %b",
                     $time, what, expected, actual);
        end
    endtask

    // One pixel clock period with the clock high for the first half
    // Inside a line a random period may carry one glitch away from the data edges
    task automatic drive_period(input logic fv, input logic lv,
                                input logic [pixel_bits-1:0] word);
        logic [31:0] rnd;
        logic        glitch_on;
        int          glitch_clock;
        int          glitch_bit;
        rng_state = xorshift32(rng_state);
        rnd = rng_state;
        glitch_on = lv && (rnd[1:0] == 2'b00);
        glitch_clock = 2 + int'(rnd[3:2]);
        glitch_bit = int'(rnd[15:8]) % pixel_bits;
        for (int c = 0; c < period_clocks; c++) begin
            @(posedge clk);
            #1;
            pixel_clock = (c < period_clocks / 2);
            frame_valid = fv;
            line_valid  = lv;
            pixel_in    = word;
            if (glitch_on && c == glitch_clock) begin
                if (rnd[4]) begin
                    line_valid = ~lv;
                end else begin
                    pixel_in[glitch_bit] = ~word[glitch_bit];
                end
            end
        end
    endtask

    task automatic run_sensor();
        for (int f = 0; f < sensor_frames; f++) begin
            repeat (frame_gap_periods) drive_period(1'b0, 1'b0, '0);
            repeat (porch_periods) drive_period(1'b1, 1'b0, '0);
            for (int ln = 0; ln < lines_in_frame; ln++) begin
                for (int px = 0; px < line_size; px++) begin
                    drive_period(1'b1, 1'b1, pixel_word(ln, px));
                end
                repeat (line_gap_periods) drive_period(1'b1, 1'b0, '0);
            end
        end
        // Close the last frame with a gap
        repeat (frame_gap_periods) drive_period(1'b0, 1'b0, '0);
    endtask

    // ************************************************************
    // Output comparison
    // ************************************************************

    // Outputs are read on the falling edge, half a clock after they settle
    always @(negedge clk) begin
        if (reset) begin
            prev_keep = 1'b0;
            prev_finished = 1'b1;
            run_count = 0;
        end else begin
            if (sample_pixel_pulse && keep_pixel) begin
                if (kept_count < total_pixels) begin
                    check_byte(data_for_fifo,
                               {4'(expected_line(kept_count / line_size)),
                                4'(kept_count % line_size)},
                               $sformatf("byte of kept pixel %0d", kept_count));
                end else begin
                    check_flag(keep_pixel, 1'b0, "keep_pixel after the image finished");
                end
                kept_count++;
                run_count++;
            end
            // A kept line closes when keep_pixel drops
            if (prev_keep && !keep_pixel) begin
                check_flag(run_count == line_size, 1'b1, "kept strobes per line");
                run_count = 0;
            end
            if (!prev_finished && image_finished) begin
                check_flag(kept_count == total_pixels, 1'b1, "pixel count at image_finished");
            end
            prev_keep = keep_pixel;
            prev_finished = image_finished;
        end
    end

    // ************************************************************
    // Run control
    // ************************************************************

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not end within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        pixel_clock = 1'b0;
        frame_valid = 1'b0;
        line_valid = 1'b0;
        pixel_in = '0;
        request_image = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_flag(image_started, 1'b0, "image_started after reset");
        check_flag(keep_pixel, 1'b0, "keep_pixel after reset");
        check_flag(sample_pixel_pulse, 1'b0, "sample_pixel_pulse after reset");
        check_flag(image_finished, 1'b1, "image_finished after reset");
        fork
            run_sensor();
            begin
                // The request lands mid-frame, so capture waits for the next gap
                repeat (request_delay) @(posedge clk);
                #1 request_image = 1'b1;
                @(posedge clk);
                #1 request_image = 1'b0;
                while (!image_started) @(negedge clk);
                while (!image_finished) @(negedge clk);
            end
        join
        @(negedge clk);
        check_flag(kept_count == total_pixels, 1'b1, "total kept pixels");
        assertion_errors = camera_interface_inst.camera_tb_properties_inst.failure_count;
        $display("Errors: %0d byte, %0d flag, %0d assertion",
                 byte_errors, flag_errors, assertion_errors);
        if (byte_errors == 0 && flag_errors == 0 && assertion_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: bench/camera_tb_properties.sv
// Camera interface properties on strobe width, keep level and image status
`timescale 1ns/1ps

module camera_tb_properties (
    input logic clk,
    input logic reset,
    input logic sample_pixel_pulse,
    input logic keep_pixel,
    input logic image_started,
    input logic image_finished
);

    // Read back by the testbench at the end of the run
    int failure_count = 0;

    // ************************************************************
    // Output strobe and status rules
    // ************************************************************

    // The FIFO write strobe is a single clock wide
    pulse_one_cycle: assert property (
        @(posedge clk) disable iff (reset)
        sample_pixel_pulse |=> !sample_pixel_pulse
    ) else begin
        failure_count++;
        $error("sample_pixel_pulse stayed high for more than one cycle");
    end

    // A pixel is only kept while an image is being captured
    keep_within_image: assert property (
        @(posedge clk) disable iff (reset)
        keep_pixel |-> image_started
    ) else begin
        failure_count++;
        $error("keep_pixel high while image_started is low");
    end

    // The two status lines always disagree
    finished_is_inverse: assert property (
        @(posedge clk) disable iff (reset)
        image_finished == !image_started
    ) else begin
        failure_count++;
        $error("image_finished is not the inverse of image_started");
    end

endmodule

// File: common/camera_pkg.sv
// Camera capture package with the shared widths and the sensor bus word
package camera_pkg;

    // ************************************************************
    // Widths shared across the capture path
    // ************************************************************

    // Sensor data bits on the parallel bus
    localparam int pixel_bits = 12;

    // Pixel and line counters are sized for the full sensor geometry
    localparam int count_bits = 12;

    // Only the upper byte of each pixel goes into the FIFO
    localparam int fifo_bits = 8;

    // Index of the sensor frame inside one interleaved image, up to 32 frames
    localparam int frame_index_bits = 5;

    // ************************************************************
    // Sensor bus word
    // ************************************************************

    // Named view of one sample of the sensor pins
    typedef struct packed {
        logic                  pixel_clock;
        logic                  frame_valid;
        logic                  line_valid;
        logic [pixel_bits-1:0] data;
    } sensor_fields_t;

    // The same 15 bits read either by field or as one flat vector
    // The flat view feeds the bitwise vote and the edge detectors
    typedef union packed {
        sensor_fields_t          fields;
        logic [pixel_bits+2:0]   raw;
    } sensor_bus_t;

endpackage

// File: design/camera_interface.sv
// Camera interface top level joining conditioning, tracking, sequencing and output
`timescale 1ns/1ps

module camera_interface
    import camera_pkg::*;
#(
    parameter int sync_stages        = 10,
    parameter int sample_delay       = 2,
    parameter int line_size          = 2592,
    parameter int lines_in_frame     = 1944,
    parameter int interleaved_frames = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pixel_clock,
    input  logic                  frame_valid,
    input  logic                  line_valid,
    input  logic [pixel_bits-1:0] pixel_in,
    input  logic                  request_image,
    output logic [fifo_bits-1:0]  data_for_fifo,
    output logic                  sample_pixel_pulse,
    output logic                  keep_pixel,
    output logic                  image_started,
    output logic                  image_finished
);

    sensor_bus_t           conditioned;
    logic                  sample_strobe;
    logic                  line_active;
    logic [count_bits-1:0] line_in_frame;
    logic [count_bits-1:0] prev_line;
    logic                  line_done_pulse;
    logic                  out_of_frame;
    logic                  streaming;
    logic [count_bits-1:0] target_line;

    // Edge pulses and the pixel index are left open as debug taps
    sensor_conditioner #(
        .sync_stages  (sync_stages),
        .sample_delay (sample_delay)
    ) sensor_conditioner_inst (
        .clk           (clk),
        .reset         (reset),
        .pixel_clock   (pixel_clock),
        .frame_valid   (frame_valid),
        .line_valid    (line_valid),
        .pixel_in      (pixel_in),
        .conditioned   (conditioned),
        .line_start    (),
        .line_end      (),
        .frame_start   (),
        .frame_end     (),
        .sample_strobe (sample_strobe)
    );

    line_tracker #(
        .line_size (line_size)
    ) line_tracker_inst (
        .clk             (clk),
        .reset           (reset),
        .conditioned     (conditioned),
        .sample_strobe   (sample_strobe),
        .line_active     (line_active),
        .pixel_index     (),
        .line_in_frame   (line_in_frame),
        .prev_line       (prev_line),
        .line_done_pulse (line_done_pulse),
        .out_of_frame    (out_of_frame)
    );

    capture_sequencer #(
        .lines_in_frame     (lines_in_frame),
        .interleaved_frames (interleaved_frames)
    ) capture_sequencer_inst (
        .clk             (clk),
        .reset           (reset),
        .request_image   (request_image),
        .line_done_pulse (line_done_pulse),
        .prev_line       (prev_line),
        .out_of_frame    (out_of_frame),
        .streaming       (streaming),
        .target_line     (target_line)
    );

    pixel_output pixel_output_inst (
        .clk                (clk),
        .reset              (reset),
        .conditioned        (conditioned),
        .sample_strobe      (sample_strobe),
        .line_active        (line_active),
        .line_in_frame      (line_in_frame),
        .target_line        (target_line),
        .streaming          (streaming),
        .data_for_fifo      (data_for_fifo),
        .sample_pixel_pulse (sample_pixel_pulse),
        .keep_pixel         (keep_pixel)
    );

    // Status toward the agent that asked for the image
    assign image_started  = streaming;
    assign image_finished = ~streaming;

endmodule

// File: design/capture_sequencer.sv
// Capture sequencer with the image FSM and the interleaved line schedule
`timescale 1ns/1ps

module capture_sequencer
    import camera_pkg::*;
#(
    parameter int lines_in_frame     = 1944,
    parameter int interleaved_frames = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  request_image,
    input  logic                  line_done_pulse,
    input  logic [count_bits-1:0] prev_line,
    input  logic                  out_of_frame,
    output logic                  streaming,
    output logic [count_bits-1:0] target_line
);

    // Lines go in pairs to keep the Bayer pattern, so the jump after a pair
    // averages out to one line in interleaved_frames
    localparam logic [count_bits-1:0] pair_jump = count_bits'(2 * interleaved_frames - 1);
    localparam logic [count_bits-1:0] fill_jump = count_bits'(interleaved_frames);
    localparam logic [count_bits-1:0] jump_limit =
        count_bits'(lines_in_frame - (2 * interleaved_frames - 1));
    localparam logic [count_bits-1:0] frame_limit = count_bits'(lines_in_frame);
    localparam logic [count_bits-1:0] last_sub_line =
        count_bits'(lines_in_frame / interleaved_frames - 1);
    localparam logic [frame_index_bits-1:0] last_frame =
        frame_index_bits'(interleaved_frames - 1);

    localparam logic [1:0] state_idle   = 2'd0;
    localparam logic [1:0] state_wait   = 2'd1;
    localparam logic [1:0] state_stream = 2'd2;

    logic [1:0]                  state;
    logic [count_bits-1:0]       line_in_sub;
    logic [frame_index_bits-1:0] frame_index;
    logic [frame_index_bits-1:0] next_index;
    logic [count_bits-1:0]       target_copy [0:2];
    logic [count_bits-1:0]       voted;
    logic [count_bits-1:0]       pair_target;
    logic [count_bits-1:0]       next_frame_first;
    logic                        advance;
    logic                        frame_done;

    assign streaming = (state == state_stream);

    // The line just finished was the one this image wanted
    assign advance    = line_done_pulse && (prev_line == target_line);
    assign frame_done = (line_in_sub >= last_sub_line);
    assign next_index = frame_index + 1'b1;

    // Each sensor frame begins two lines further down than the one before
    assign next_frame_first = count_bits'({next_index, 1'b0});

    // Even target means the second line of the pair comes next
    // When the jump would leave the frame, the same step lands on the odd lines that
    // earlier frames lost at the cut of their final pair
    always_comb begin
        if (target_line[0] == 1'b0) begin
            pair_target = target_line + 1'b1;
        end else if (target_line < jump_limit) begin
            pair_target = target_line + pair_jump;
        end else begin
            pair_target = target_line + fill_jump;
        end
    end

    // ************************************************************
    // Image FSM
    // ************************************************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= state_idle;
        end else begin
            case (state)
                state_idle: begin
                    if (request_image) begin
                        state <= state_wait;
                    end
                end
                // Start only in a frame gap so the first line of a frame is caught
                state_wait: begin
                    if (out_of_frame) begin
                        state <= state_stream;
                    end
                end
                state_stream: begin
                    if (advance && frame_done && frame_index >= last_frame) begin
                        state <= state_idle;
                    end else if (target_line >= frame_limit) begin
                        // Several upsets left the target off the frame and it would
                        // never match, so the image is cut short instead of hanging
                        state <= state_idle;
                    end
                end
                default: begin
                    state <= state_idle;
                end
            endcase
        end
    end

    // ************************************************************
    // Interleave schedule and voted target
    // ************************************************************

    // A single upset in the target would stall the capture on a line that never
    // comes, so three copies are kept and voted
    assign voted = (target_copy[0] & target_copy[1])
                 | (target_copy[0] & target_copy[2])
                 | (target_copy[1] & target_copy[2]);

    always_ff @(posedge clk) begin
        if (reset || !streaming) begin
            line_in_sub <= '0;
            frame_index <= '0;
            for (int k = 0; k < 3; k++) begin
                target_copy[k] <= '0;
            end
        end else if (advance) begin
            if (frame_done) begin
                line_in_sub <= '0;
                if (frame_index < last_frame) begin
                    frame_index <= next_index;
                    for (int k = 0; k < 3; k++) begin
                        target_copy[k] <= next_frame_first;
                    end
                end
            end else begin
                line_in_sub <= line_in_sub + 1'b1;
                for (int k = 0; k < 3; k++) begin
                    target_copy[k] <= pair_target;
                end
            end
        end
    end

    // The voted value lags the copies by a clock, well inside the line blanking
    always_ff @(posedge clk) begin
        if (reset) begin
            target_line <= '0;
        end else begin
            target_line <= voted;
        end
    end

endmodule

// File: design/line_tracker.sv
// Line tracker that follows pixel position, line state and line number in a frame
`timescale 1ns/1ps

module line_tracker
    import camera_pkg::*;
#(
    parameter int line_size = 2592
) (
    input  logic                  clk,
    input  logic                  reset,
    input  sensor_bus_t           conditioned,
    input  logic                  sample_strobe,
    output logic                  line_active,
    output logic [count_bits-1:0] pixel_index,
    output logic [count_bits-1:0] line_in_frame,
    output logic [count_bits-1:0] prev_line,
    output logic                  line_done_pulse,
    output logic                  out_of_frame
);

    localparam logic [count_bits-1:0] line_end_count = count_bits'(line_size);

    logic blank_data;
    logic frame_gap;
    logic line_over;
    // Set once a line has been active and cleared when the line counter advances
    logic count_pending;

    // Blanking is recognised by all data bits being zero
    assign blank_data = (conditioned.fields.data == '0);

    // Inter-frame gap, trusted only when every input agrees
    assign frame_gap = !conditioned.fields.frame_valid
                    && !conditioned.fields.line_valid
                    && blank_data;

    // The line is over once the full count is in and the bus shows line blanking
    assign line_over = !conditioned.fields.line_valid
                    && !line_active
                    && blank_data
                    && count_pending;

    // ************************************************************
    // Line state and pixel counter
    // ************************************************************

    // pixel_index is the index of the pixel being sampled up to the strobe and
    // the number of pixels taken afterwards
    always_ff @(posedge clk) begin
        if (reset) begin
            line_active <= 1'b0;
            pixel_index <= '0;
        end else if (line_active) begin
            // Greater or equal so an upset past the end still closes the line
            if (pixel_index >= line_end_count) begin
                line_active <= 1'b0;
                pixel_index <= '0;
            end else if (sample_strobe) begin
                pixel_index <= pixel_index + 1'b1;
            end
        end else if (conditioned.fields.line_valid && !count_pending) begin
            // A finished line must be counted before line_valid may start a new one
            // otherwise the tail of line_valid would reopen the same line
            line_active <= 1'b1;
        end
    end

    // ************************************************************
    // Line counter
    // ************************************************************

    // Lines are counted in the blanking after each line, where the inputs can be
    // cross-checked and there is time to spare
    always_ff @(posedge clk) begin
        if (reset) begin
            line_in_frame   <= '0;
            prev_line       <= '0;
            count_pending   <= 1'b0;
            line_done_pulse <= 1'b0;
            out_of_frame    <= 1'b0;
        end else begin
            line_done_pulse <= 1'b0;
            out_of_frame    <= frame_gap;
            if (line_active) begin
                count_pending <= 1'b1;
            end
            if (line_over) begin
                count_pending   <= 1'b0;
                prev_line       <= line_in_frame;
                line_in_frame   <= line_in_frame + 1'b1;
                line_done_pulse <= 1'b1;
            end else if (frame_gap && !line_active && line_in_frame != '0) begin
                // The increment of the last line wins, and the wrap follows a clock later
                prev_line     <= line_in_frame;
                line_in_frame <= '0;
            end
        end
    end

endmodule

// File: design/pixel_output.sv
// Pixel output stage that presents the byte, keep level and strobe to the FIFO
`timescale 1ns/1ps

module pixel_output
    import camera_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  sensor_bus_t           conditioned,
    input  logic                  sample_strobe,
    input  logic                  line_active,
    input  logic [count_bits-1:0] line_in_frame,
    input  logic [count_bits-1:0] target_line,
    input  logic                  streaming,
    output logic [fifo_bits-1:0]  data_for_fifo,
    output logic                  sample_pixel_pulse,
    output logic                  keep_pixel
);

    // Upper bits of the filtered pixel, reloaded every clock
    always_ff @(posedge clk) begin
        data_for_fifo <= conditioned.fields.data[pixel_bits-1 -: fifo_bits];
    end

    // The strobe is the FIFO write clock and keep_pixel is its write enable
    // Both are delayed alongside the data so all three line up in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sample_pixel_pulse <= 1'b0;
            keep_pixel         <= 1'b0;
        end else begin
            sample_pixel_pulse <= sample_strobe;
            keep_pixel         <= line_active
                               && (line_in_frame == target_line)
                               && streaming;
        end
    end

endmodule

// File: design/sensor_conditioner.sv
// Sensor conditioner that synchronizes, votes and edge-detects the camera bus
`timescale 1ns/1ps

module sensor_conditioner
    import camera_pkg::*;
#(
    parameter int sync_stages  = 10,
    parameter int sample_delay = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pixel_clock,
    input  logic                  frame_valid,
    input  logic                  line_valid,
    input  logic [pixel_bits-1:0] pixel_in,
    output sensor_bus_t           conditioned,
    output logic                  line_start,
    output logic                  line_end,
    output logic                  frame_start,
    output logic                  frame_end,
    output logic                  sample_strobe
);

    sensor_bus_t             pin_word;
    sensor_bus_t             sync_chain [0:sync_stages-1];
    sensor_bus_t             vote_buffer [0:2];
    sensor_bus_t             majority;
    sensor_bus_t             rising;
    sensor_bus_t             falling;
    logic [sample_delay-1:0] strobe_pipe;

    // All pins travel as one word so every signal sees the same latency
    always_comb begin
        pin_word.fields.pixel_clock = pixel_clock;
        pin_word.fields.frame_valid = frame_valid;
        pin_word.fields.line_valid  = line_valid;
        pin_word.fields.data        = pixel_in;
    end

    // ************************************************************
    // Synchronizer and vote buffer
    // ************************************************************

    // The chain is far deeper than metastability needs, since latency is free here
    // and only its uniformity matters
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < sync_stages; i++) begin
                sync_chain[i] <= '0;
            end
            for (int k = 0; k < 3; k++) begin
                vote_buffer[k] <= '0;
            end
            conditioned <= '0;
        end else begin
            sync_chain[0] <= pin_word;
            for (int i = 1; i < sync_stages; i++) begin
                sync_chain[i] <= sync_chain[i-1];
            end
            vote_buffer[0] <= sync_chain[sync_stages-1];
            vote_buffer[1] <= vote_buffer[0];
            vote_buffer[2] <= vote_buffer[1];
            // Registered vote, which is the filtered stream seen downstream
            conditioned <= majority;
        end
    end

    // Two out of three per bit, so a blip that lasts one clock never gets through
    // With 8 system clocks per pixel clock period three samples still fit in a phase
    assign majority.raw = (vote_buffer[2].raw & vote_buffer[1].raw)
                        | (vote_buffer[2].raw & vote_buffer[0].raw)
                        | (vote_buffer[1].raw & vote_buffer[0].raw);

    // ************************************************************
    // Edge detection and sample strobe
    // ************************************************************

    // Edges compare the new vote with the registered one
    // Each pulse lasts one clock and precedes the change on conditioned by a clock
    assign rising.raw  = majority.raw & ~conditioned.raw;
    assign falling.raw = ~majority.raw & conditioned.raw;

    assign line_start  = rising.fields.line_valid;
    assign line_end    = falling.fields.line_valid;
    assign frame_start = rising.fields.frame_valid;
    assign frame_end   = falling.fields.frame_valid;

    // The sensor changes data on the pixel clock rise, so sampling a little after
    // the fall lands in the middle of a stable data window
    always_ff @(posedge clk) begin
        if (reset) begin
            strobe_pipe <= '0;
        end else begin
            strobe_pipe[0] <= falling.fields.pixel_clock;
            for (int i = 1; i < sample_delay; i++) begin
                strobe_pipe[i] <= strobe_pipe[i-1];
            end
        end
    end

    assign sample_strobe = strobe_pipe[sample_delay-1];

endmodule

// File: verilog.f
common/camera_pkg.sv
design/sensor_conditioner.sv
design/line_tracker.sv
design/capture_sequencer.sv
design/pixel_output.sv
design/camera_interface.sv
bench/camera_tb_properties.sv
bench/camera_tb.sv
